//--- hdl/fifo_defs.svh
// Async FIFO size definitions
`ifndef FIFO_DEFS_SVH
`define FIFO_DEFS_SVH

// ========================================
// Geometry
// ========================================

// Address bits into the storage array
// Pointers carry one more bit for wrap
`define FIFO_ADDR_WIDTH 3

// Number of storage entries
// Always a power of two so Gray wrap works
`define FIFO_DEPTH (1 << `FIFO_ADDR_WIDTH)

// ========================================
// Payload
// ========================================

// Bits per stored data word
`define FIFO_DATA_WIDTH 16

`endif

//--- hdl/async_fifo_pkg.sv
// Async FIFO types
`include "fifo_defs.svh"

package async_fifo_pkg;

    // ========================================
    // Pointer and data types
    // ========================================

    // Memory address, low pointer bits only
    typedef logic [`FIFO_ADDR_WIDTH-1:0] fifo_addr_t;

    // Binary pointer, top bit is the wrap bit
    typedef logic [`FIFO_ADDR_WIDTH:0] fifo_ptr_t;

    // Gray form of a pointer, same width
    typedef logic [`FIFO_ADDR_WIDTH:0] gray_ptr_t;

    // One stored word
    typedef logic [`FIFO_DATA_WIDTH-1:0] fifo_data_t;

    // Binary to Gray conversion
    // Shared by both pointer controllers
    function automatic gray_ptr_t bin_to_gray(input fifo_ptr_t bin);
        return gray_ptr_t'(bin ^ (bin >> 1));
    endfunction

endpackage

//--- hdl/fifo_mem_if.sv
// FIFO memory port bundle
`timescale 1ns/1ns

interface fifo_mem_if import async_fifo_pkg::*; ();

    // Write side, wr_clk domain
    // One-cycle strobe per stored word
    logic       wr_en;
    fifo_addr_t wr_addr;
    fifo_data_t wr_data;

    // Read side, rd_clk domain
    // Data comes back combinationally
    fifo_addr_t rd_addr;
    fifo_data_t rd_data;

    // ========================================
    // Modports
    // ========================================

    // Write pointer controller
    modport wr (
        output wr_en,
        output wr_addr,
        output wr_data
    );

    // Read pointer controller
    modport rd (
        output rd_addr,
        input  rd_data
    );

    // Dual-port storage array
    modport ram (
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  rd_addr,
        output rd_data
    );

endinterface

//--- hdl/gray_sync.sv
// Gray pointer synchronizer
`timescale 1ns/1ns

module gray_sync import async_fifo_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  gray_ptr_t gray_in,
    output gray_ptr_t gray_out
);

    // First stage, may go metastable
    gray_ptr_t sync_q1;

    // ========================================
    // Two-flop crossing
    // ========================================

    // Only one bit moves per pointer step
    // so the second stage sees either the old
    // or the new value, never a blend
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_q1  <= '0;
            gray_out <= '0;
        end else begin
            sync_q1  <= gray_in;
            // Settled copy for the destination domain
            gray_out <= sync_q1;
        end
    end

    // Source pointer must come straight from a register
    // in the source domain, with no logic in between
    // Reset value matches both pointer registers

endmodule

//--- hdl/wr_ptr_ctrl.sv
// Write pointer controller
`timescale 1ns/1ns
`include "fifo_defs.svh"

module wr_ptr_ctrl import async_fifo_pkg::*; (
    input  logic       wr_clk,
    input  logic       reset,
    input  logic       write,
    input  fifo_data_t wr_data,
    input  gray_ptr_t  rd_gray_wr,
    output logic       full,
    output gray_ptr_t  wr_gray,
    fifo_mem_if.wr     mem
);

    // Binary write pointer with wrap bit
    fifo_ptr_t wr_ptr;
    // Pointer after one accepted write
    fifo_ptr_t wr_ptr_next;
    // Write strobe qualified by full
    logic      wr_accept;
    // Read pointer as it must look when full
    gray_ptr_t rd_gray_full;

    // ========================================
    // Accept and advance
    // ========================================

    // Writes while full are dropped here
    assign wr_accept   = write && !full;
    assign wr_ptr_next = wr_ptr + 1'b1;

    // Binary and Gray copies move together
    // Gray copy is registered so the crossing sees a clean value
    always_ff @(posedge wr_clk or posedge reset) begin
        if (reset) begin
            wr_ptr  <= '0;
            wr_gray <= '0;
        end else if (wr_accept) begin
            wr_ptr  <= wr_ptr_next;
            wr_gray <= bin_to_gray(wr_ptr_next);
        end
    end

    // ========================================
    // Full flag
    // ========================================

    // Writer is one lap ahead of the reader
    // In Gray code that means the top two bits differ
    // and the rest match
    assign rd_gray_full = {~rd_gray_wr[`FIFO_ADDR_WIDTH:`FIFO_ADDR_WIDTH-1],
                           rd_gray_wr[`FIFO_ADDR_WIDTH-2:0]};

    // Comparison of two registers, so full tracks
    // the write pointer in the same cycle
    assign full = (wr_gray == rd_gray_full);

    // ========================================
    // Memory write port
    // ========================================

    // Low pointer bits address the array
    assign mem.wr_en   = wr_accept;
    assign mem.wr_addr = wr_ptr[`FIFO_ADDR_WIDTH-1:0];
    assign mem.wr_data = wr_data;

endmodule

//--- hdl/rd_ptr_ctrl.sv
// Read pointer controller
`timescale 1ns/1ns
`include "fifo_defs.svh"

module rd_ptr_ctrl import async_fifo_pkg::*; (
    input  logic       rd_clk,
    input  logic       reset,
    input  logic       read,
    input  gray_ptr_t  wr_gray_rd,
    output logic       empty,
    output fifo_data_t rd_data,
    output gray_ptr_t  rd_gray,
    fifo_mem_if.rd     mem
);

    // Binary read pointer with wrap bit
    fifo_ptr_t rd_ptr;
    // Pointer after one accepted read
    fifo_ptr_t rd_ptr_next;
    // Read strobe qualified by empty
    logic      rd_accept;

    // ========================================
    // Accept and advance
    // ========================================

    // Reads of an empty FIFO change nothing
    assign rd_accept   = read && !empty;
    assign rd_ptr_next = rd_ptr + 1'b1;

    // Both pointer forms step on the same edge
    always_ff @(posedge rd_clk or posedge reset) begin
        if (reset) begin
            rd_ptr  <= '0;
            rd_gray <= '0;
        end else if (rd_accept) begin
            rd_ptr  <= rd_ptr_next;
            rd_gray <= bin_to_gray(rd_ptr_next);
        end
    end

    // ========================================
    // Empty flag
    // ========================================

    // Pointers equal including the wrap bit
    // means nothing is left to read
    // The write pointer lags by the sync delay,
    // so empty may stay high a little long but
    // never drops early
    assign empty = (rd_gray == wr_gray_rd);

    // ========================================
    // Memory read port
    // ========================================

    // Head of the FIFO sits at the read pointer
    assign mem.rd_addr = rd_ptr[`FIFO_ADDR_WIDTH-1:0];

    // Fall-through output
    // Next word shows right after an accepted read
    assign rd_data = mem.rd_data;

endmodule

//--- hdl/fifo_dual_port_ram.sv
// FIFO storage array
`timescale 1ns/1ns
`include "fifo_defs.svh"

module fifo_dual_port_ram import async_fifo_pkg::*; (
    input  logic    wr_clk,
    fifo_mem_if.ram mem
);

    // ========================================
    // Storage
    // ========================================

    // One word per entry, no reset
    fifo_data_t ram_q [`FIFO_DEPTH];

    // Write port in the wr_clk domain
    // wr_en is already qualified by full
    always_ff @(posedge wr_clk) begin
        if (mem.wr_en) begin
            ram_q[mem.wr_addr] <= mem.wr_data;
        end
    end

    // ========================================
    // Read port
    // ========================================

    // Asynchronous read, gives fall-through timing
    // The entry at rd_addr was written at least
    // two rd_clk edges before empty could drop,
    // so it is stable when sampled
    assign mem.rd_data = ram_q[mem.rd_addr];

endmodule

//--- hdl/async_fifo_top.sv
// Asynchronous FIFO top level
`timescale 1ns/1ns

module async_fifo_top import async_fifo_pkg::*; (
    input  logic       wr_clk,
    input  logic       rd_clk,
    input  logic       reset,
    input  logic       write,
    input  fifo_data_t wr_data,
    input  logic       read,
    output logic       full,
    output logic       empty,
    output fifo_data_t rd_data
);

    // Gray pointers in their home domains
    gray_ptr_t wr_gray;
    gray_ptr_t rd_gray;
    // Gray pointers after crossing
    gray_ptr_t wr_gray_rd;
    gray_ptr_t rd_gray_wr;

    // Memory ports between controllers and RAM
    fifo_mem_if mem_if ();

    // ========================================
    // Write domain
    // ========================================

    wr_ptr_ctrl wr_ptr_ctrl_i (
        .wr_clk     (wr_clk),
        .reset      (reset),
        .write      (write),
        .wr_data    (wr_data),
        .rd_gray_wr (rd_gray_wr),
        .full       (full),
        .wr_gray    (wr_gray),
        .mem        (mem_if.wr)
    );

    // Read pointer into wr_clk
    gray_sync rd_gray_sync_i (
        .clk      (wr_clk),
        .reset    (reset),
        .gray_in  (rd_gray),
        .gray_out (rd_gray_wr)
    );

    // ========================================
    // Read domain
    // ========================================

    rd_ptr_ctrl rd_ptr_ctrl_i (
        .rd_clk     (rd_clk),
        .reset      (reset),
        .read       (read),
        .wr_gray_rd (wr_gray_rd),
        .empty      (empty),
        .rd_data    (rd_data),
        .rd_gray    (rd_gray),
        .mem        (mem_if.rd)
    );

    // Write pointer into rd_clk
    gray_sync wr_gray_sync_i (
        .clk      (rd_clk),
        .reset    (reset),
        .gray_in  (wr_gray),
        .gray_out (wr_gray_rd)
    );

    // Storage, written in wr_clk and read combinationally
    fifo_dual_port_ram fifo_dual_port_ram_i (
        .wr_clk (wr_clk),
        .mem    (mem_if.ram)
    );

endmodule

//--- testbench/async_fifo_tb.sv
// Async FIFO testbench
`timescale 1ns/1ns
`include "fifo_defs.svh"

module async_fifo_tb;

    typedef logic [`FIFO_DATA_WIDTH-1:0] word_t;

    // Cycle limit for any single wait loop
    localparam int WAIT_LIMIT = 200;
    // Length of the random traffic phase, in each clock
    localparam int WR_CYCLES  = 2000;
    localparam int RD_CYCLES  = 3000;

    // Clocks start low so the first edge is a rising one
    logic  wr_clk = 1'b0;
    logic  rd_clk = 1'b0;
    logic  reset;
    logic  write;
    word_t wr_data;
    logic  read;
    logic  full;
    logic  empty;
    word_t rd_data;

    // Expected FIFO contents, head at index 0
    word_t model_q[$];

    // Random traffic, generated up front in one process
    logic  wr_pat      [WR_CYCLES];
    word_t wr_data_pat [WR_CYCLES];
    logic  rd_pat      [RD_CYCLES];

    // Bookkeeping
    int    wr_accepts;
    int    rd_accepts;
    int    errors;
    int    timeouts;
    int    tests_run;
    int    tests_failed;
    int    test_start_problems;
    string cur_test;

    async_fifo_top async_fifo_top_i (
        .wr_clk  (wr_clk),
        .rd_clk  (rd_clk),
        .reset   (reset),
        .write   (write),
        .wr_data (wr_data),
        .read    (read),
        .full    (full),
        .empty   (empty),
        .rd_data (rd_data)
    );

    // ========================================
    // Clocks
    // ========================================

    // 4 ns read clock
    initial begin
        forever #2 rd_clk = ~rd_clk;
    end

    // 6 ns write clock, rising edges never meet rd_clk's
    initial begin
        forever #3 wr_clk = ~wr_clk;
    end

    // ========================================
    // Reporting helpers
    // ========================================

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERROR %s %s: expected %0h actual %0h", cur_test, what, expected, actual);
        errors++;
    endtask

    task automatic report_timeout(input string what);
        $display("TIMEOUT %s: %s did not happen within %0d cycles",
                 cur_test, what, WAIT_LIMIT);
        timeouts++;
    endtask

    task automatic start_test(input string name);
        cur_test            = name;
        test_start_problems = errors + timeouts;
    endtask

    // One summary line per test
    task automatic finish_test();
        int problems;
        problems = errors + timeouts - test_start_problems;
        tests_run++;
        if (problems == 0) begin
            $display("test %-12s pass", cur_test);
        end else begin
            tests_failed++;
            $display("test %-12s fail, %0d problem(s)", cur_test, problems);
        end
    endtask

    // ========================================
    // Model updates at the rising edges
    // ========================================

    // Write side, acceptance from pre-edge values
    always @(posedge wr_clk) begin
        if (!reset) begin
            // A truly full FIFO must show full to the writer
            if (model_q.size() == `FIFO_DEPTH && full !== 1'b1) begin
                report_mismatch("full with model at depth", 32'd1, 32'(full));
            end
            if (write && !full) begin
                if (model_q.size() >= `FIFO_DEPTH) begin
                    $display("ERROR %s: write accepted with the model already at depth",
                             cur_test);
                    errors++;
                end
                model_q.push_back(wr_data);
                wr_accepts++;
            end
        end
    end

    // Read side, head word checked before the pop
    always @(posedge rd_clk) begin
        if (!reset) begin
            // Nothing stored means empty must be seen
            if (model_q.size() == 0 && empty !== 1'b1) begin
                report_mismatch("empty with model drained", 32'd1, 32'(empty));
            end
            if (read && !empty) begin
                if (model_q.size() == 0) begin
                    $display("ERROR %s: read accepted with nothing in the model", cur_test);
                    errors++;
                end else begin
                    if (rd_data !== model_q[0]) begin
                        report_mismatch("rd_data", 32'(model_q[0]), 32'(rd_data));
                    end
                    void'(model_q.pop_front());
                end
                rd_accepts++;
            end
        end
    end

    // Read on falling rd_clk edges until empty
    task automatic drain_until_empty(output int words_read);
        int timer;
        int start_count;
        start_count = rd_accepts;
        timer       = 0;
        @(negedge rd_clk);
        while (!empty && timer < WAIT_LIMIT) begin
            read = 1'b1;
            @(negedge rd_clk);
            timer++;
        end
        read = 1'b0;
        if (!empty) begin
            report_timeout("empty rising");
        end
        words_read = rd_accepts - start_count;
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial begin
        int          start_count;
        int          timer;
        int          words_read;
        int          i;
        int          wr_idx;
        int          rd_idx;
        word_t       expected_word;

        void'($urandom(32'h6de468b8));
        reset        = 1'b1;
        write        = 1'b0;
        read         = 1'b0;
        wr_data      = '0;
        wr_accepts   = 0;
        rd_accepts   = 0;
        errors       = 0;
        timeouts     = 0;
        tests_run    = 0;
        tests_failed = 0;

        // Flags held in their reset state
        start_test("reset_state");
        repeat (4) @(negedge rd_clk);
        if (full !== 1'b0) report_mismatch("full in reset", 32'd0, 32'(full));
        if (empty !== 1'b1) report_mismatch("empty in reset", 32'd1, 32'(empty));
        repeat (4) @(negedge rd_clk);
        reset = 1'b0;
        repeat (2) @(negedge wr_clk);
        if (full !== 1'b0) report_mismatch("full after reset", 32'd0, 32'(full));
        if (empty !== 1'b1) report_mismatch("empty after reset", 32'd1, 32'(empty));
        finish_test();

        // Write until full, then push against it
        start_test("fill");
        start_count = wr_accepts;
        timer       = 0;
        @(negedge wr_clk);
        while (!full && timer < WAIT_LIMIT) begin
            write   = 1'b1;
            wr_data = word_t'($urandom);
            @(negedge wr_clk);
            timer++;
        end
        if (!full) report_timeout("full rising");
        if (wr_accepts - start_count != `FIFO_DEPTH) begin
            report_mismatch("accepted writes", `FIFO_DEPTH, wr_accepts - start_count);
        end
        start_count = wr_accepts;
        repeat (4) begin
            wr_data = word_t'($urandom);
            @(negedge wr_clk);
        end
        write = 1'b0;
        if (wr_accepts != start_count) begin
            report_mismatch("writes accepted while full", 32'd0, wr_accepts - start_count);
        end
        if (model_q.size() != `FIFO_DEPTH) begin
            report_mismatch("model words", `FIFO_DEPTH, model_q.size());
        end
        finish_test();

        // Words come back in order, exactly DEPTH of them
        start_test("drain_order");
        drain_until_empty(words_read);
        if (words_read != `FIFO_DEPTH) begin
            report_mismatch("words drained", `FIFO_DEPTH, words_read);
        end
        finish_test();

        // Reads of an empty FIFO, then one word through
        start_test("read_empty");
        start_count = rd_accepts;
        repeat (6) begin
            @(negedge rd_clk);
            read = 1'b1;
        end
        @(negedge rd_clk);
        read = 1'b0;
        if (rd_accepts != start_count) begin
            report_mismatch("reads accepted while empty", 32'd0, rd_accepts - start_count);
        end
        if (empty !== 1'b1) report_mismatch("empty", 32'd1, 32'(empty));
        @(negedge wr_clk);
        expected_word = word_t'($urandom);
        write         = 1'b1;
        wr_data       = expected_word;
        @(negedge wr_clk);
        write = 1'b0;
        // Empty falls once the write pointer has crossed
        timer = 0;
        while (empty && timer < WAIT_LIMIT) begin
            @(negedge rd_clk);
            timer++;
        end
        if (empty) begin
            report_timeout("empty falling");
        end else if (rd_data !== expected_word) begin
            report_mismatch("rd_data", 32'(expected_word), 32'(rd_data));
        end
        read = 1'b1;
        @(negedge rd_clk);
        read = 1'b0;
        if (empty !== 1'b1) report_mismatch("empty after last read", 32'd1, 32'(empty));
        finish_test();

        // Both sides at once, write bias swings between phases
        start_test("random");
        for (i = 0; i < WR_CYCLES; i++) begin
            wr_pat[i]      = ($urandom % 100) < (((i / 250) % 2 == 0) ? 85 : 30);
            wr_data_pat[i] = word_t'($urandom);
        end
        for (i = 0; i < RD_CYCLES; i++) begin
            rd_pat[i] = ($urandom % 100) < 40;
        end
        fork
            begin
                for (wr_idx = 0; wr_idx < WR_CYCLES; wr_idx++) begin
                    @(negedge wr_clk);
                    write   = wr_pat[wr_idx];
                    wr_data = wr_data_pat[wr_idx];
                end
                @(negedge wr_clk);
                write = 1'b0;
            end
            begin
                for (rd_idx = 0; rd_idx < RD_CYCLES; rd_idx++) begin
                    @(negedge rd_clk);
                    read = rd_pat[rd_idx];
                end
                @(negedge rd_clk);
                read = 1'b0;
            end
        join
        // Last write pointer crosses within 3 rd_clk edges
        repeat (4) @(negedge rd_clk);
        drain_until_empty(words_read);
        if (model_q.size() != 0) begin
            report_mismatch("model words after drain", 32'd0, model_q.size());
        end
        finish_test();

        $display("tests run %0d, tests failed %0d, errors %0d, timeouts %0d",
                 tests_run, tests_failed, errors, timeouts);
        if (errors == 0 && timeouts == 0 && tests_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+hdl
hdl/async_fifo_pkg.sv
hdl/fifo_mem_if.sv
hdl/gray_sync.sv
hdl/wr_ptr_ctrl.sv
hdl/rd_ptr_ctrl.sv
hdl/fifo_dual_port_ram.sv
hdl/async_fifo_top.sv
testbench/async_fifo_tb.sv

//--- Makefile
# Verilator build and run for the async FIFO

VERILATOR  ?= verilator
TOP        ?= async_fifo_tb
RTL_TOP    ?= async_fifo_top
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= TB PASSED
JOBS       ?= 0
VFLAGS     ?= --binary --timing -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall
INCDIRS    ?= +incdir+hdl

# RTL sources in compile order, package first
RTL_SRCS ?= hdl/async_fifo_pkg.sv \
            hdl/fifo_mem_if.sv \
            hdl/gray_sync.sv \
            hdl/wr_ptr_ctrl.sv \
            hdl/rd_ptr_ctrl.sv \
            hdl/fifo_dual_port_ram.sv \
            hdl/async_fifo_top.sv

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Pass or fail comes from the log, not the exit status of the binary
run: build
	./$(SIM_BIN) | tee $(LOG)
	@grep -qxF "$(PASS_MSG)" $(LOG) || \
		(echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) $(INCDIRS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
